//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int wordSize = 16;

    // Instruction field positions
    localparam int opMsb = 15;
    localparam int opLsb = 12;
    localparam int rsMsb = 11;
    localparam int rsLsb = 10;
    localparam int rtMsb = 9;
    localparam int rtLsb = 8;
    localparam int rdMsb = 7;
    localparam int rdLsb = 6;
    localparam int funcMsb = 5;
    localparam int funcLsb = 0;
    localparam int immMsb = 7;
    localparam int immLsb = 0;
    localparam int targetMsb = 11;
    localparam int targetLsb = 0;

    typedef logic [1:0] regIdxT;

    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        BGZ   = 4'd2,
        BLZ   = 4'd3,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        RTYPE = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        JPR = 6'd25,
        WWD = 6'd28,
        HLT = 6'd29
    } funcT;

endpackage

`default_nettype wire

//--- hdl/pipePkg.sv
`default_nettype none

package pipePkg;
    import isaPkg::*;

    // First eight follow the R-type function codes
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOrr   = 4'd3,
        aluNot   = 4'd4,
        aluTcp   = 4'd5,
        aluShl   = 4'd6,
        aluShr   = 4'd7,
        aluPassB = 4'd8,
        aluLhi   = 4'd9
    } aluOpT;

    // Operand source for EX
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdMem  = 2'd1,
        fwdWb   = 2'd2
    } fwdSelT;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;
        logic   isBranch;
        logic   isJumpR;
        logic   isJumpI;
        logic   isWwd;
        logic   isHalt;
        aluOpT  aluOp;
        logic   useRs;
        logic   useRt;
        regIdxT destReg;
    } ctrlT;

endpackage

`default_nettype wire

//--- hdl/ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import isaPkg::*, pipePkg::*; ();

    logic [wordSize-1:0] idInstr;
    logic                idValid;
    // Older branch or JPR in EX kills the ID instruction
    logic                idFlush;
    ctrlT                idCtrl;

    modport decode (
        input  idInstr, idValid, idFlush,
        output idCtrl
    );

    modport pipe (
        output idInstr, idValid, idFlush,
        input  idCtrl
    );

endinterface

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import isaPkg::*, pipePkg::*; (
    input  aluOpT               aluOp,
    input  logic [wordSize-1:0] opA,
    input  logic [wordSize-1:0] opB,
    output logic [wordSize-1:0] result,
    input  opcodeT              branchOp,
    output logic                branchTaken
);

    always_comb begin
        case (aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluAnd:   result = opA & opB;
            aluOrr:   result = opA | opB;
            aluNot:   result = ~opA;
            aluTcp:   result = ~opA + wordSize'(1);
            aluShl:   result = {opA[wordSize-2:0], 1'b0};
            // Arithmetic shift
            aluShr:   result = {opA[wordSize-1], opA[wordSize-1:1]};
            aluPassB: result = opB;
            aluLhi:   result = {opB[7:0], {(wordSize-8){1'b0}}};
            default:  result = opA + opB;
        endcase
    end

    always_comb begin
        case (branchOp)
            BNE:     branchTaken = (opA != opB);
            BEQ:     branchTaken = (opA == opB);
            BGZ:     branchTaken = !opA[wordSize-1] && (opA != '0);
            BLZ:     branchTaken = opA[wordSize-1];
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import isaPkg::*; (
    input  logic                Clk,
    input  logic                rstN,
    input  regIdxT              readIdx1,
    input  regIdxT              readIdx2,
    output logic [wordSize-1:0] readData1,
    output logic [wordSize-1:0] readData2,
    input  logic                writeEn,
    input  regIdxT              writeIdx,
    input  logic [wordSize-1:0] writeData
);

    logic [wordSize-1:0] regs [4];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            foreach (regs[i]) regs[i] <= '0;
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    // WB write seen by ID in the same cycle
    assign readData1 = (writeEn && writeIdx == readIdx1) ? writeData : regs[readIdx1];
    assign readData2 = (writeEn && writeIdx == readIdx2) ? writeData : regs[readIdx2];

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import isaPkg::*, pipePkg::*; (
    input  regIdxT rsIdx,
    input  regIdxT rtIdx,
    input  logic   useRs,
    input  logic   useRt,
    input  regIdxT exDest,
    input  logic   exMemRead,
    input  regIdxT memDest,
    input  logic   memRegWrite,
    input  regIdxT wbDest,
    input  logic   wbRegWrite,
    output logic   stall,
    output fwdSelT fwdA,
    output fwdSelT fwdB
);

    // Selects are decided in ID and used one cycle later in EX,
    // so mem* is the producer that will then sit in EXMEM and
    // wb* the one that will sit in MEMWB
    function automatic fwdSelT pickSource(regIdxT idx, logic used);
        if (used && memRegWrite && memDest == idx) begin
            return fwdMem;
        end
        if (used && wbRegWrite && wbDest == idx) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign fwdA = pickSource(rsIdx, useRs);
    assign fwdB = pickSource(rtIdx, useRt);

    // Load data arrives too late for the next instruction
    assign stall = exMemRead &&
                   ((useRs && rsIdx == exDest) || (useRt && rtIdx == exDest));

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import isaPkg::*, pipePkg::*; (
    ctrlIf.decode cif
);

    opcodeT op;
    funcT   func;
    regIdxT rt;
    regIdxT rd;
    ctrlT   dec;

    assign op   = opcodeT'(cif.idInstr[opMsb:opLsb]);
    assign func = funcT'(cif.idInstr[funcMsb:funcLsb]);
    assign rt   = cif.idInstr[rtMsb:rtLsb];
    assign rd   = cif.idInstr[rdMsb:rdLsb];

    always_comb begin
        dec = '0;
        dec.aluOp = aluAdd;
        case (op)
            BNE, BEQ, BGZ, BLZ: begin
                dec.isBranch = 1'b1;
                dec.useRs = 1'b1;
                dec.useRt = (op == BNE) || (op == BEQ);
            end
            ADI, ORI, LHI, LWD: begin
                dec.regWrite = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.useRs = (op != LHI);
                dec.destReg = rt;
                dec.memRead = (op == LWD);
                dec.memToReg = (op == LWD);
                if (op == ORI) begin
                    dec.aluOp = aluOrr;
                end else if (op == LHI) begin
                    dec.aluOp = aluLhi;
                end
            end
            SWD: begin
                dec.memWrite = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.useRs = 1'b1;
                dec.useRt = 1'b1;
            end
            JMP: dec.isJumpI = 1'b1;
            RTYPE: begin
                case (func)
                    ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR: begin
                        dec.regWrite = 1'b1;
                        dec.useRs = 1'b1;
                        dec.useRt = func inside {ADD, SUB, AND, ORR};
                        dec.destReg = rd;
                        dec.aluOp = aluOpT'(func[3:0]);
                    end
                    JPR: begin
                        dec.isJumpR = 1'b1;
                        dec.useRs = 1'b1;
                    end
                    // Operand goes through read port B
                    WWD: begin
                        dec.isWwd = 1'b1;
                        dec.useRt = 1'b1;
                        dec.aluOp = aluPassB;
                    end
                    HLT: dec.isHalt = 1'b1;
                    default: dec = '0;
                endcase
            end
            default: dec = '0;
        endcase
    end

    assign cif.idCtrl = (cif.idValid && !cif.idFlush) ? dec : '0;

endmodule

`default_nettype wire

//--- hdl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import isaPkg::*, pipePkg::*; #(
    parameter logic [wordSize-1:0] resetPc = '0
) (
    input  logic                Clk,
    input  logic                rstN,
    ctrlIf.pipe                 cif,
    output logic                instrRead,
    output logic [wordSize-1:0] instrAddr,
    input  logic [wordSize-1:0] instrData,
    output logic                dataRead,
    output logic                dataWrite,
    output logic [wordSize-1:0] dataAddr,
    output logic [wordSize-1:0] dataWdata,
    input  logic [wordSize-1:0] dataRdata,
    output logic [wordSize-1:0] outputPort,
    output logic                outputValid,
    output logic [wordSize-1:0] numInst,
    output logic                isHalted
);

    logic [wordSize-1:0] pc;
    logic                haltFetch;
    logic                fetchTake;

    logic                ifidValid;
    logic [wordSize-1:0] ifidInstr;
    logic [wordSize-1:0] ifidPc;

    ctrlT                idCtrl;
    opcodeT              idOp;
    regIdxT              idRs;
    regIdxT              idRt;
    regIdxT              idSrcB;
    logic [wordSize-1:0] idImm;
    logic [wordSize-1:0] idReadA;
    logic [wordSize-1:0] idReadB;
    logic [wordSize-1:0] idJumpTarget;
    logic                stall;
    fwdSelT              idFwdA;
    fwdSelT              idFwdB;

    logic                idexValid;
    ctrlT                idexCtrl;
    opcodeT              idexOp;
    logic [wordSize-1:0] idexPc;
    logic [wordSize-1:0] idexA;
    logic [wordSize-1:0] idexB;
    logic [wordSize-1:0] idexImm;
    fwdSelT              idexFwdA;
    fwdSelT              idexFwdB;

    logic [wordSize-1:0] exA;
    logic [wordSize-1:0] exB;
    logic [wordSize-1:0] exAluB;
    logic [wordSize-1:0] exResult;
    logic [wordSize-1:0] exTarget;
    logic                exBranchTaken;
    logic                exRedirect;

    logic                exmemValid;
    ctrlT                exmemCtrl;
    logic [wordSize-1:0] exmemResult;
    logic [wordSize-1:0] exmemStore;

    logic                memwbValid;
    ctrlT                memwbCtrl;
    logic [wordSize-1:0] memwbResult;
    logic [wordSize-1:0] memwbLoad;
    logic [wordSize-1:0] wbData;

    // IF
    assign instrRead = !(haltFetch || idCtrl.isHalt);
    assign instrAddr = pc;
    assign fetchTake = !exRedirect && !stall && !idCtrl.isJumpI && instrRead;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
            ifidValid <= 1'b0;
            haltFetch <= 1'b0;
        end else begin
            if (exRedirect) begin
                pc <= exTarget;
            end else if (!stall) begin
                if (idCtrl.isJumpI) begin
                    pc <= idJumpTarget;
                end else if (instrRead) begin
                    pc <= pc + wordSize'(1);
                end
            end
            if (exRedirect || !stall) begin
                ifidValid <= fetchTake;
            end
            if (idCtrl.isHalt && !stall) begin
                haltFetch <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (fetchTake) begin
            ifidInstr <= instrData;
            ifidPc <= pc;
        end
    end

    // ID
    assign cif.idInstr = ifidInstr;
    assign cif.idValid = ifidValid;
    assign cif.idFlush = exRedirect;
    assign idCtrl = cif.idCtrl;

    assign idOp = opcodeT'(ifidInstr[opMsb:opLsb]);
    assign idRs = ifidInstr[rsMsb:rsLsb];
    assign idRt = ifidInstr[rtMsb:rtLsb];
    // WWD reads rs on port B
    assign idSrcB = idCtrl.isWwd ? idRs : idRt;
    assign idImm = (idOp == ORI) ?
                   {{(wordSize-8){1'b0}}, ifidInstr[immMsb:immLsb]} :
                   {{(wordSize-8){ifidInstr[immMsb]}}, ifidInstr[immMsb:immLsb]};
    assign idJumpTarget = {ifidPc[wordSize-1:targetMsb+1], ifidInstr[targetMsb:targetLsb]};

    regFile uRegFile (
        .Clk       (Clk),
        .rstN      (rstN),
        .readIdx1  (idRs),
        .readIdx2  (idSrcB),
        .readData1 (idReadA),
        .readData2 (idReadB),
        .writeEn   (memwbCtrl.regWrite),
        .writeIdx  (memwbCtrl.destReg),
        .writeData (wbData)
    );

    hazardUnit uHazard (
        .rsIdx       (idRs),
        .rtIdx       (idSrcB),
        .useRs       (idCtrl.useRs),
        .useRt       (idCtrl.useRt),
        .exDest      (idexCtrl.destReg),
        .exMemRead   (idexCtrl.memRead),
        .memDest     (idexCtrl.destReg),
        .memRegWrite (idexCtrl.regWrite),
        .wbDest      (exmemCtrl.destReg),
        .wbRegWrite  (exmemCtrl.regWrite),
        .stall       (stall),
        .fwdA        (idFwdA),
        .fwdB        (idFwdB)
    );

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            idexValid <= 1'b0;
            idexCtrl <= '0;
        end else begin
            idexValid <= ifidValid && !exRedirect && !stall;
            idexCtrl <= stall ? '0 : idCtrl;
        end
    end

    always_ff @(posedge Clk) begin
        idexOp <= idOp;
        idexPc <= ifidPc;
        idexA <= idReadA;
        idexB <= idReadB;
        idexImm <= idImm;
        idexFwdA <= idFwdA;
        idexFwdB <= idFwdB;
    end

    // EX
    always_comb begin
        case (idexFwdA)
            fwdMem:  exA = exmemResult;
            fwdWb:   exA = wbData;
            default: exA = idexA;
        endcase
        case (idexFwdB)
            fwdMem:  exB = exmemResult;
            fwdWb:   exB = wbData;
            default: exB = idexB;
        endcase
    end

    assign exAluB = idexCtrl.aluSrcImm ? idexImm : exB;

    alu uAlu (
        .aluOp       (idexCtrl.aluOp),
        .opA         (exA),
        .opB         (exAluB),
        .result      (exResult),
        .branchOp    (idexOp),
        .branchTaken (exBranchTaken)
    );

    assign exRedirect = (idexCtrl.isBranch && exBranchTaken) || idexCtrl.isJumpR;
    assign exTarget = idexCtrl.isJumpR ? exA : idexPc + wordSize'(1) + idexImm;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            exmemValid <= 1'b0;
            exmemCtrl <= '0;
            memwbValid <= 1'b0;
            memwbCtrl <= '0;
        end else begin
            exmemValid <= idexValid;
            exmemCtrl <= idexCtrl;
            memwbValid <= exmemValid;
            memwbCtrl <= exmemCtrl;
        end
    end

    always_ff @(posedge Clk) begin
        exmemResult <= exResult;
        exmemStore <= exB;
        memwbResult <= exmemResult;
        memwbLoad <= dataRdata;
    end

    // MEM
    assign dataRead = exmemCtrl.memRead;
    assign dataWrite = exmemCtrl.memWrite;
    assign dataAddr = exmemResult;
    assign dataWdata = exmemStore;

    // WB and retire
    assign wbData = memwbCtrl.memToReg ? memwbLoad : memwbResult;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            numInst <= '0;
            outputPort <= '0;
            outputValid <= 1'b0;
            isHalted <= 1'b0;
        end else begin
            outputValid <= memwbValid && memwbCtrl.isWwd;
            if (memwbValid) begin
                numInst <= numInst + wordSize'(1);
            end
            if (memwbValid && memwbCtrl.isWwd) begin
                outputPort <= memwbResult;
            end
            if (memwbValid && memwbCtrl.isHalt) begin
                isHalted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import isaPkg::*; #(
    parameter logic [wordSize-1:0] resetPc = '0
) (
    input  logic                Clk,
    input  logic                rstN,
    output logic                instrRead,
    output logic [wordSize-1:0] instrAddr,
    input  logic [wordSize-1:0] instrData,
    output logic                dataRead,
    output logic                dataWrite,
    output logic [wordSize-1:0] dataAddr,
    output logic [wordSize-1:0] dataWdata,
    input  logic [wordSize-1:0] dataRdata,
    output logic [wordSize-1:0] outputPort,
    output logic                outputValid,
    output logic [wordSize-1:0] numInst,
    output logic                isHalted
);

    ctrlIf cif ();

    controlUnit uControl (
        .cif (cif.decode)
    );

    datapath #(
        .resetPc (resetPc)
    ) uDatapath (
        .Clk         (Clk),
        .rstN        (rstN),
        .cif         (cif.pipe),
        .instrRead   (instrRead),
        .instrAddr   (instrAddr),
        .instrData   (instrData),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .dataRdata   (dataRdata),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .isHalted    (isHalted)
    );

endmodule

`default_nettype wire

//--- tb/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpuAssert (
    input logic Clk,
    input logic rstN,
    input logic instrRead,
    input logic dataRead,
    input logic dataWrite,
    input logic outputValid,
    input logic isHalted
);

    // One data access per cycle
    noReadWrite: assert property (@(posedge Clk) disable iff (!rstN)
        !(dataRead && dataWrite))
        else $error("dataRead and dataWrite high in the same cycle");

    quietAfterHalt: assert property (@(posedge Clk) disable iff (!rstN)
        isHalted |-> !$rose(outputValid))
        else $error("outputValid rose while halted");

    noFetchHalted: assert property (@(posedge Clk) disable iff (!rstN)
        isHalted |-> !instrRead)
        else $error("instrRead high while halted");

endmodule

bind datapath cpuAssert uCpuAssert (
    .Clk         (Clk),
    .rstN        (rstN),
    .instrRead   (instrRead),
    .dataRead    (dataRead),
    .dataWrite   (dataWrite),
    .outputValid (outputValid),
    .isHalted    (isHalted)
);

`default_nettype wire

//--- tb/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import isaPkg::*; ();

    localparam int numPrograms = 6;
    localparam int bodyLen = 38;
    localparam int progMax = 64;
    localparam int imemWords = 1024;
    localparam int dmemWords = 256;
    localparam int resetCycles = 10;
    localparam int haltTimeout = 600;
    localparam int settleCycles = 6;
    localparam logic [31:0] seed = 32'h1323e737;

    logic                Clk;
    logic                rstN;
    logic                instrRead;
    logic [wordSize-1:0] instrAddr;
    logic [wordSize-1:0] instrData;
    logic                dataRead;
    logic                dataWrite;
    logic [wordSize-1:0] dataAddr;
    logic [wordSize-1:0] dataWdata;
    logic [wordSize-1:0] dataRdata;
    logic [wordSize-1:0] outputPort;
    logic                outputValid;
    logic [wordSize-1:0] numInst;
    logic                isHalted;

    logic [15:0] imem [imemWords];
    logic [15:0] dmem [dmemWords];
    logic [15:0] mdmem [dmemWords];
    logic [15:0] prog [progMax];
    logic [15:0] expWwd [$];
    int          groupStart [$];
    int          patchAt [$];
    int          patchGroup [$];
    int          patchKind [$];
    int          progLen;
    int          expCount;
    int          wwdSeen;
    int          checkErrors;
    int          outErrors;
    logic [31:0] rngState;
    logic [15:0] fillSalt;

    cpu dut (
        .Clk         (Clk),
        .rstN        (rstN),
        .instrRead   (instrRead),
        .instrAddr   (instrAddr),
        .instrData   (instrData),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .dataRdata   (dataRdata),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .isHalted    (isHalted)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // Memories answer in the same cycle as their read strobe
    assign instrData = instrRead ? imem[instrAddr[9:0]] : '0;
    assign dataRdata = dataRead ? dmem[dataAddr[7:0]] : '0;

    always @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= fillWord(8'(i), fillSalt);
            end
        end else if (dataWrite) begin
            dmem[dataAddr[7:0]] <= dataWdata;
        end
    end

    // WWD results in program order
    always @(negedge Clk) begin
        if (!rstN) begin
            wwdSeen = 0;
        end else if (outputValid) begin
            if (isHalted) begin
                outErrors++;
                $display("Output pulse seen while the core was halted");
            end
            if (wwdSeen >= expWwd.size()) begin
                outErrors++;
                $display("Unexpected extra output pulse, value %h", outputPort);
            end else if (outputPort !== expWwd[wwdSeen]) begin
                outErrors++;
                $display("Fail at %0t: WWD %0d gave %h, expected %h",
                         $time, wwdSeen, outputPort, expWwd[wwdSeen]);
            end
            wwdSeen++;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic int randBelow(int n);
        rngState = xorshift(rngState);
        return int'(rngState % 32'(n));
    endfunction

    function automatic logic [15:0] fillWord(logic [7:0] a, logic [15:0] salt);
        return {a ^ salt[15:8], ~a ^ salt[7:0]};
    endfunction

    function automatic logic [15:0] iWord(opcodeT op, regIdxT rs, regIdxT rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rWord(regIdxT rs, regIdxT rt, regIdxT rd, funcT fn);
        return {RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] jWord(logic [11:0] target);
        return {JMP, target};
    endfunction

    function automatic void appendWord(logic [15:0] w);
        prog[progLen] = w;
        progLen++;
    endfunction

    // Control transfer whose target is filled in once all groups exist
    function automatic void markTarget(int kind);
        patchAt.push_back(progLen);
        patchGroup.push_back(groupStart.size() - 1);
        patchKind.push_back(kind);
    endfunction

    task automatic genProgram();
        int     kind;
        int     g;
        int     tgt;
        regIdxT a;
        regIdxT b;
        regIdxT c;
        progLen = 0;
        groupStart.delete();
        patchAt.delete();
        patchGroup.delete();
        patchKind.delete();
        while (progLen < bodyLen) begin
            groupStart.push_back(progLen);
            kind = randBelow(16);
            a = 2'(randBelow(4));
            b = 2'(randBelow(4));
            c = 2'(randBelow(4));
            if (kind < 5) begin
                appendWord(rWord(a, b, c, funcT'(6'(randBelow(8)))));
            end else if (kind == 5) begin
                appendWord(iWord(ADI, a, b, 8'(randBelow(256))));
            end else if (kind == 6) begin
                appendWord(iWord(ORI, a, b, 8'(randBelow(256))));
            end else if (kind == 7) begin
                appendWord(iWord(LHI, 2'd0, b, 8'(randBelow(256))));
            end else if (kind < 10) begin
                appendWord(rWord(a, 2'd0, 2'd0, WWD));
            end else if (kind < 12) begin
                // Base register into the data area
                appendWord(iWord(LHI, 2'd0, b, 8'h01));
                appendWord(iWord(ORI, b, b, 8'(randBelow(64))));
                if (kind == 10) begin
                    appendWord(iWord(LWD, b, c, 8'(randBelow(16) - 8)));
                    if (randBelow(2) == 1) begin
                        appendWord(rWord(c, 2'd0, 2'd0, WWD));
                    end
                end else begin
                    appendWord(iWord(SWD, b, c, 8'(randBelow(16) - 8)));
                end
            end else if (kind < 14) begin
                markTarget(0);
                appendWord(iWord(opcodeT'(4'(randBelow(4))), a, b, 8'h00));
            end else if (kind == 14) begin
                markTarget(1);
                appendWord(jWord(12'h000));
            end else begin
                appendWord(iWord(LHI, 2'd0, a, 8'h00));
                markTarget(2);
                appendWord(iWord(ORI, a, a, 8'h00));
                appendWord(rWord(a, 2'd0, 2'd0, JPR));
            end
        end
        groupStart.push_back(progLen);
        appendWord(rWord(2'd0, 2'd0, 2'd0, HLT));
        // Targets go forward only and never into the middle of a group
        for (int i = 0; i < patchAt.size(); i++) begin
            g = patchGroup[i] + 1 + randBelow(4);
            if (g > groupStart.size() - 1) begin
                g = groupStart.size() - 1;
            end
            tgt = groupStart[g];
            case (patchKind[i])
                0: prog[patchAt[i]][7:0] = 8'(tgt - patchAt[i] - 1);
                1: prog[patchAt[i]][11:0] = 12'(tgt);
                default: prog[patchAt[i]][7:0] = 8'(tgt);
            endcase
        end
    endtask

    // Sequential ISA model stepping one instruction at a time
    task automatic runModel();
        logic [15:0] r [4];
        logic [15:0] pc;
        logic [15:0] npc;
        logic [15:0] ins;
        logic [15:0] simm;
        logic [15:0] addr;
        opcodeT      op;
        funcT        fn;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        logic        done;
        for (int i = 0; i < dmemWords; i++) begin
            mdmem[i] = fillWord(8'(i), fillSalt);
        end
        for (int i = 0; i < 4; i++) begin
            r[i] = 16'h0000;
        end
        expWwd.delete();
        expCount = 0;
        pc = 16'h0000;
        done = 1'b0;
        while (!done && expCount < 1000) begin
            ins = imem[pc[9:0]];
            op = opcodeT'(ins[15:12]);
            fn = funcT'(ins[5:0]);
            rs = ins[11:10];
            rt = ins[9:8];
            rd = ins[7:6];
            simm = {{8{ins[7]}}, ins[7:0]};
            addr = r[rs] + simm;
            npc = pc + 16'd1;
            expCount++;
            case (op)
                BNE: if (r[rs] != r[rt]) npc = pc + 16'd1 + simm;
                BEQ: if (r[rs] == r[rt]) npc = pc + 16'd1 + simm;
                BGZ: if ($signed(r[rs]) > 16'sd0) npc = pc + 16'd1 + simm;
                BLZ: if ($signed(r[rs]) < 16'sd0) npc = pc + 16'd1 + simm;
                ADI: r[rt] = r[rs] + simm;
                ORI: r[rt] = r[rs] | {8'h00, ins[7:0]};
                LHI: r[rt] = {ins[7:0], 8'h00};
                LWD: r[rt] = mdmem[addr[7:0]];
                SWD: mdmem[addr[7:0]] = r[rt];
                JMP: npc = {pc[15:12], ins[11:0]};
                RTYPE: begin
                    case (fn)
                        ADD: r[rd] = r[rs] + r[rt];
                        SUB: r[rd] = r[rs] - r[rt];
                        AND: r[rd] = r[rs] & r[rt];
                        ORR: r[rd] = r[rs] | r[rt];
                        NOT: r[rd] = ~r[rs];
                        TCP: r[rd] = -r[rs];
                        SHL: r[rd] = r[rs] << 1;
                        SHR: r[rd] = $signed(r[rs]) >>> 1;
                        JPR: npc = r[rs];
                        WWD: expWwd.push_back(r[rs]);
                        HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
            pc = npc;
        end
    endtask

    task automatic runProgram(int p);
        int cycles;
        @(posedge Clk);
        rstN <= 1'b0;
        genProgram();
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = (i < progLen) ? prog[i] : rWord(2'd0, 2'd0, 2'd0, HLT);
        end
        fillSalt = 16'(randBelow(65536));
        runModel();
        $display("Program %0d: %0d words, %0d retired, %0d outputs in the model",
                 p, progLen, expCount, expWwd.size());
        repeat (resetCycles) @(posedge Clk);
        rstN <= 1'b1;
        cycles = 0;
        while (isHalted !== 1'b1 && cycles < haltTimeout) begin
            @(negedge Clk);
            cycles++;
        end
        if (isHalted !== 1'b1) begin
            checkErrors++;
            $display("Program %0d: the core did not halt within %0d cycles", p, haltTimeout);
        end else begin
            repeat (settleCycles) begin
                @(negedge Clk);
                if (isHalted !== 1'b1) begin
                    checkErrors++;
                    $display("Program %0d: isHalted dropped after the halt", p);
                end
            end
            if (numInst !== 16'(expCount)) begin
                checkErrors++;
                $display("Fail at %0t: numInst %0d, expected %0d", $time, numInst, expCount);
            end
            if (wwdSeen != expWwd.size()) begin
                checkErrors++;
                $display("Fail at %0t: %0d output pulses, expected %0d",
                         $time, wwdSeen, expWwd.size());
            end
            for (int i = 0; i < dmemWords; i++) begin
                if (dmem[i] !== mdmem[i]) begin
                    checkErrors++;
                    $display("Fail at %0t: data word %0d is %h, expected %h",
                             $time, i, dmem[i], mdmem[i]);
                end
            end
        end
    endtask

    initial begin
        rstN <= 1'b0;
        rngState = seed;
        fillSalt = 16'h0000;
        checkErrors = 0;
        outErrors = 0;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = rWord(2'd0, 2'd0, 2'd0, HLT);
        end
        for (int p = 0; p < numPrograms; p++) begin
            runProgram(p);
        end
        $display("Errors: %0d in checks after halt, %0d on the output port",
                 checkErrors, outErrors);
        if (checkErrors == 0 && outErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/ctrlIf.sv
hdl/alu.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/controlUnit.sv
hdl/datapath.sv
hdl/cpu.sv
tb/cpu_assert.sv
tb/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
rm -rf obj_dir sim.log &&
verilator --binary --assert --top-module cpuTb -f sim.f -o cpuSim &&
./obj_dir/cpuSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
